// ==== bdd_apply.f ====
+incdir+src
+incdir+dv
src/bdd_apply_pkg.sv
src/bdd_pipe_reg.sv
src/bdd_terminal_check.sv
src/bdd_cache_lookup.sv
src/bdd_result_merge.sv
src/bdd_apply_front.sv
dv/bdd_apply_front_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f bdd_apply.f \
	--top-module bdd_apply_front_tb \
	-o bdd_apply_sim

./obj_dir/bdd_apply_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi

// ==== dv/bdd_apply_ref.svh ====
`ifndef BDD_APPLY_REF_SVH
`define BDD_APPLY_REF_SVH

// Expected terminal verdict, packed as {hit, result}
function automatic logic [`BDD_INDEX_W:0] terminal_rule(
	input logic [`BDD_TYPE_W-1:0]  op,
	input logic [`BDD_INDEX_W-1:0] f,
	input logic [`BDD_INDEX_W-1:0] g
);
	logic f0;
	logic g0;
	logic f1;
	logic g1;
	logic flipped;
	f0 = (f == `BDD_NODE_FALSE);
	g0 = (g == `BDD_NODE_FALSE);
	f1 = (f == `BDD_NODE_TRUE);
	g1 = (g == `BDD_NODE_TRUE);
	flipped = (f == (g ^ `BDD_NODE_TRUE)); // f is NOT g
	case (op)
		3'd0:
		begin
			if (f0 || g0 || flipped) return {1'b1, `BDD_NODE_FALSE};
			if (f1) return {1'b1, g};
			if (g1 || f == g) return {1'b1, f};
		end
		3'd1:
		begin
			if (f1 || g1 || flipped) return {1'b1, `BDD_NODE_TRUE};
			if (f0) return {1'b1, g};
			if (g0 || f == g) return {1'b1, f};
		end
		3'd2:
		begin
			if (f0) return {1'b1, g};
			if (g0) return {1'b1, f};
			if (f == g) return {1'b1, `BDD_NODE_FALSE};
			if (flipped) return {1'b1, `BDD_NODE_TRUE};
			if (f1) return {1'b1, g ^ `BDD_NODE_TRUE};
			if (g1) return {1'b1, f ^ `BDD_NODE_TRUE};
		end
		3'd3, 3'd4:
		begin
			if (f <= `BDD_NODE_TRUE) return {1'b1, f}; // Constant f
		end
		default:
		begin
		end
	endcase
	return {1'b0, `BDD_NODE_FALSE};
endfunction

// Canonical operand order {f, g}, smaller index first for AND, OR and XOR
function automatic logic [2*`BDD_INDEX_W-1:0] order_operands(
	input logic [`BDD_TYPE_W-1:0]  op,
	input logic [`BDD_INDEX_W-1:0] f,
	input logic [`BDD_INDEX_W-1:0] g
);
	if (op <= 3'd2 && f > g)
	begin
		return {g, f};
	end
	return {f, g};
endfunction

// Cache slot of an ordered request
function automatic logic [`BDD_CACHE_ADDR_W-1:0] cache_index(
	input logic [`BDD_INDEX_W-1:0] f,
	input logic [`BDD_INDEX_W-1:0] g,
	input logic [`BDD_TYPE_W-1:0]  op
);
	logic [`BDD_CACHE_ADDR_W-1:0] op_bits;
	op_bits = {5'b00000, op} << 5;
	return f[7:0] ^ f[15:8] ^ g[7:0] ^ g[23:16] ^ op_bits;
endfunction

`endif

// ==== dv/bdd_apply_front_tb.sv ====
`timescale 1ns/100ps

`include "bdd_apply_macros.svh"

module bdd_apply_front_tb;

	localparam int SEND_LIMIT = 500; // Cycles a request may wait for in_ready
	localparam int DRAIN_LIMIT = 2000;

	typedef struct packed {
		logic [`BDD_REQ_ID_W-1:0] id;
		logic                     hit;
		logic [`BDD_INDEX_W-1:0]  result;
		logic [`BDD_INDEX_W-1:0]  f;
		logic [`BDD_INDEX_W-1:0]  g;
		logic [`BDD_TYPE_W-1:0]   op;
		logic [31:0]              stamp; // Cycle of the input transfer
	} expect_t;

	logic                     clk;
	logic                     reset;
	logic                     in_valid;
	logic                     in_ready;
	logic [`BDD_REQ_ID_W-1:0] in_id;
	logic                     in_negate;
	logic [`BDD_INDEX_W-1:0]  in_f;
	logic [`BDD_INDEX_W-1:0]  in_g;
	logic [`BDD_TYPE_W-1:0]   in_op;
	logic                     insert_valid;
	logic [`BDD_INDEX_W-1:0]  insert_f;
	logic [`BDD_INDEX_W-1:0]  insert_g;
	logic [`BDD_TYPE_W-1:0]   insert_op;
	logic [`BDD_INDEX_W-1:0]  insert_result;
	logic                     out_valid;
	logic                     out_ready = 1'b1;
	logic [`BDD_REQ_ID_W-1:0] out_id;
	logic                     out_hit;
	logic [`BDD_INDEX_W-1:0]  out_result;
	logic [`BDD_INDEX_W-1:0]  out_f;
	logic [`BDD_INDEX_W-1:0]  out_g;
	logic [`BDD_TYPE_W-1:0]   out_op;

	// Cache model, one slot per hash value
	logic                    model_valid [`BDD_CACHE_DEPTH];
	logic [`BDD_INDEX_W-1:0] model_f [`BDD_CACHE_DEPTH];
	logic [`BDD_INDEX_W-1:0] model_g [`BDD_CACHE_DEPTH];
	logic [`BDD_TYPE_W-1:0]  model_op [`BDD_CACHE_DEPTH];
	logic [`BDD_INDEX_W-1:0] model_result [`BDD_CACHE_DEPTH];

	expect_t     exp_q [$];
	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;
	int          stall_count = 0;
	logic        check_latency = 1'b0;
	logic        random_ready = 1'b0;
	logic [31:0] stim_state = 32'h48d5;
	logic [31:0] ready_state = 32'h48d5;

	`include "bdd_apply_ref.svh"

	bdd_apply_front dut0 (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_id        (in_id),
		.in_negate    (in_negate),
		.in_f         (in_f),
		.in_g         (in_g),
		.in_op        (in_op),
		.insert_valid (insert_valid),
		.insert_f     (insert_f),
		.insert_g     (insert_g),
		.insert_op    (insert_op),
		.insert_result(insert_result),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_id       (out_id),
		.out_hit      (out_hit),
		.out_result   (out_result),
		.out_f        (out_f),
		.out_g        (out_g),
		.out_op       (out_op)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) cycle_count <= cycle_count + 1;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Mix of constants, a small range that hits the cache, and wide indices
	function automatic logic [`BDD_INDEX_W-1:0] pick_node(input logic [31:0] r);
		case (r[31:30])
			2'd0: return {{(`BDD_INDEX_W-1){1'b0}}, r[20]};
			2'd1: return 30'd2 + 30'(r[27:24]);
			default: return r[29:0];
		endcase
	endfunction

	function automatic logic [`BDD_TYPE_W-1:0] pick_op(input logic [31:0] r);
		return 3'(r[31:16] % 16'd5);
	endfunction

	// Terminal rules first, then the cache model, then negation on a hit
	function automatic expect_t expected_response(
		input logic [`BDD_REQ_ID_W-1:0] id,
		input logic                     negate,
		input logic [`BDD_INDEX_W-1:0]  f,
		input logic [`BDD_INDEX_W-1:0]  g,
		input logic [`BDD_TYPE_W-1:0]   op
	);
		expect_t                      e;
		logic [`BDD_INDEX_W:0]        term;
		logic [`BDD_CACHE_ADDR_W-1:0] idx;
		term = terminal_rule(op, f, g);
		{e.f, e.g} = order_operands(op, f, g);
		e.id = id;
		e.op = op;
		e.stamp = 32'd0;
		e.hit = term[`BDD_INDEX_W];
		e.result = term[`BDD_INDEX_W-1:0];
		idx = cache_index(e.f, e.g, op);
		if (!e.hit && model_valid[idx] && model_f[idx] == e.f && model_g[idx] == e.g
			&& model_op[idx] == op)
		begin
			e.hit = 1'b1;
			e.result = model_result[idx];
		end
		if (e.hit)
		begin
			e.result[0] = e.result[0] ^ negate;
		end
		return e;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < `BDD_CACHE_DEPTH; i++)
		begin
			model_valid[i] = 1'b0; // Reset empties the cache
		end
	endtask

	task automatic send_req(
		input logic [`BDD_REQ_ID_W-1:0] id,
		input logic                     negate,
		input logic [`BDD_INDEX_W-1:0]  f,
		input logic [`BDD_INDEX_W-1:0]  g,
		input logic [`BDD_TYPE_W-1:0]   op
	);
		int waited;
		waited = 0;
		in_valid = 1'b1;
		in_id = id;
		in_negate = negate;
		in_f = f;
		in_g = g;
		in_op = op;
		@(posedge clk);
		while (!in_ready && waited < SEND_LIMIT)
		begin
			waited++;
			stall_count++;
			@(posedge clk);
		end
		if (!in_ready)
		begin
			$display("Timeout: request %0d was never accepted at %0t", id, $time);
			errors++;
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Operands must already be in canonical order
	task automatic insert_entry(
		input logic [`BDD_INDEX_W-1:0] f,
		input logic [`BDD_INDEX_W-1:0] g,
		input logic [`BDD_TYPE_W-1:0]  op,
		input logic [`BDD_INDEX_W-1:0] result
	);
		logic [`BDD_CACHE_ADDR_W-1:0] idx;
		idx = cache_index(f, g, op);
		insert_valid = 1'b1;
		insert_f = f;
		insert_g = g;
		insert_op = op;
		insert_result = result;
		@(negedge clk);
		insert_valid = 1'b0;
		model_valid[idx] = 1'b1;
		model_f[idx] = f;
		model_g[idx] = g;
		model_op[idx] = op;
		model_result[idx] = result;
	endtask

	// Waits for all outstanding responses, then reports the test
	task automatic finish_test(input string name);
		int waited;
		int n;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			waited++;
			@(negedge clk);
		end
		if (exp_q.size() != 0)
		begin
			$display("Timeout: %0d responses never arrived at %0t", exp_q.size(), $time);
			errors++;
			exp_q.delete();
		end
		repeat (4) @(negedge clk); // Quiet gap exposes duplicates
		n = errors - test_errors;
		tests_run++;
		if (n != 0)
		begin
			tests_failed++;
		end
		$display("Test %0d (%s) finished with %0d errors", tests_run, name, n);
		test_errors = errors;
	endtask

	// Input monitor builds the expected response at each transfer
	always @(posedge clk)
	begin
		expect_t e;
		if (!reset && in_valid && in_ready)
		begin
			e = expected_response(in_id, in_negate, in_f, in_g, in_op);
			e.stamp = cycle_count;
			exp_q.push_back(e);
		end
	end

	always @(posedge clk)
	begin
		expect_t e;
		if (!reset && out_valid && out_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Unexpected response with id %0d at %0t", out_id, $time);
				errors++;
			end
			else
			begin
				e = exp_q.pop_front();
				check_value("id", 32'(out_id), 32'(e.id));
				check_value("hit", 32'(out_hit), 32'(e.hit));
				if (e.hit)
				begin
					check_value("result", 32'(out_result), 32'(e.result));
				end
				check_value("f", 32'(out_f), 32'(e.f));
				check_value("g", 32'(out_g), 32'(e.g));
				check_value("op", 32'(out_op), 32'(e.op));
				if (check_latency)
				begin
					check_value("latency", cycle_count - e.stamp, 32'd3);
				end
			end
		end
	end

	always @(negedge clk)
	begin
		if (random_ready)
		begin
			ready_state = lcg_next(ready_state);
			out_ready = ready_state[20];
		end
		else
		begin
			out_ready = 1'b1;
		end
	end

	initial
	begin
		logic [`BDD_INDEX_W-1:0] a;
		logic [`BDD_INDEX_W-1:0] b;
		int                      op;
		int                      neg;
		int                      k;
		reset = 1'b1;
		in_valid = 1'b0;
		in_id = '0;
		in_negate = 1'b0;
		in_f = '0;
		in_g = '0;
		in_op = '0;
		insert_valid = 1'b0;
		insert_f = '0;
		insert_g = '0;
		insert_op = '0;
		insert_result = '0;
		apply_reset();

		a = 30'h1a4;
		b = 30'h2c6;
		for (op = 0; op < 5; op++)
		begin
			for (neg = 0; neg < 2; neg++)
			begin
				send_req(3'(op), neg[0], `BDD_NODE_FALSE, a, 3'(op));
				send_req(3'(op), neg[0], a, `BDD_NODE_FALSE, 3'(op));
				send_req(3'(op), neg[0], `BDD_NODE_TRUE, a, 3'(op));
				send_req(3'(op), neg[0], a, `BDD_NODE_TRUE, 3'(op));
				send_req(3'(op), neg[0], a, a, 3'(op));
				send_req(3'(op), neg[0], a, a ^ `BDD_NODE_TRUE, 3'(op));
				send_req(3'(op), neg[0], `BDD_NODE_FALSE, `BDD_NODE_TRUE, 3'(op));
				send_req(3'(op), neg[0], `BDD_NODE_TRUE, `BDD_NODE_FALSE, 3'(op));
				send_req(3'(op), neg[0], `BDD_NODE_TRUE, `BDD_NODE_TRUE, 3'(op));
				send_req(3'(op), neg[0], `BDD_NODE_FALSE, `BDD_NODE_FALSE, 3'(op));
				send_req(3'(op), neg[0], a, b, 3'(op));
			end
		end
		finish_test("terminal rules");

		for (k = 0; k < 3; k++)
		begin
			send_req(3'(k + 4), 1'b0, 30'h3c00 + 30'(k), 30'h1240, 3'(k));
		end
		finish_test("operand ordering");

		insert_entry(30'h204, 30'h308, 3'd0, 30'h5a5a4);
		insert_entry(30'h11c, 30'h2f0, 3'd1, 30'h777);
		insert_entry(30'h40a, 30'h122, 3'd3, 30'h1234);
		send_req(3'd1, 1'b0, 30'h204, 30'h308, 3'd0);
		send_req(3'd2, 1'b1, 30'h308, 30'h204, 3'd0);
		send_req(3'd3, 1'b1, 30'h2f0, 30'h11c, 3'd1);
		send_req(3'd4, 1'b0, 30'h40a, 30'h122, 3'd3);
		send_req(3'd5, 1'b0, 30'h204, 30'h1308, 3'd0); // Same slot, other tag
		finish_test("cache hits");

		apply_reset();
		send_req(3'd1, 1'b0, 30'h204, 30'h308, 3'd0);
		send_req(3'd3, 1'b1, 30'h2f0, 30'h11c, 3'd1);
		send_req(3'd4, 1'b0, 30'h40a, 30'h122, 3'd3);
		finish_test("reset flush");

		// Small operand range so random requests find these entries
		for (k = 0; k < 24; k++)
		begin
			stim_state = lcg_next(stim_state);
			a = 30'd2 + 30'(stim_state[27:24]);
			b = 30'd2 + 30'(stim_state[23:20]);
			op = int'(pick_op(stim_state));
			{a, b} = order_operands(3'(op), a, b);
			insert_entry(a, b, 3'(op), stim_state[29:0]);
		end
		random_ready = 1'b1;
		for (k = 0; k < 200; k++)
		begin
			stim_state = lcg_next(stim_state);
			a = pick_node(stim_state);
			stim_state = lcg_next(stim_state);
			b = pick_node(stim_state);
			stim_state = lcg_next(stim_state);
			send_req(stim_state[18:16], stim_state[23], a, b, pick_op(stim_state));
		end
		finish_test("random stream");
		random_ready = 1'b0;
		@(negedge clk);

		check_latency = 1'b1;
		stall_count = 0;
		for (k = 0; k < 20; k++)
		begin
			stim_state = lcg_next(stim_state);
			a = pick_node(stim_state);
			stim_state = lcg_next(stim_state);
			send_req(3'(k), stim_state[23], a, pick_node(stim_state), pick_op(stim_state));
		end
		check_value("stalled cycles", 32'(stall_count), 32'd0);
		finish_test("latency and throughput");
		check_latency = 1'b0;

		$display("%0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_failed, errors);
		if (errors == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== src/bdd_apply_front.sv ====
`timescale 1ns/100ps

`include "bdd_apply_macros.svh"

module bdd_apply_front (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [`BDD_REQ_ID_W-1:0] in_id,
	input  logic                     in_negate,
	input  logic [`BDD_INDEX_W-1:0]  in_f,
	input  logic [`BDD_INDEX_W-1:0]  in_g,
	input  logic [`BDD_TYPE_W-1:0]   in_op,
	input  logic                     insert_valid,
	input  logic [`BDD_INDEX_W-1:0]  insert_f,
	input  logic [`BDD_INDEX_W-1:0]  insert_g,
	input  logic [`BDD_TYPE_W-1:0]   insert_op,
	input  logic [`BDD_INDEX_W-1:0]  insert_result,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic [`BDD_REQ_ID_W-1:0] out_id,
	output logic                     out_hit,
	output logic [`BDD_INDEX_W-1:0]  out_result,
	output logic [`BDD_INDEX_W-1:0]  out_f,
	output logic [`BDD_INDEX_W-1:0]  out_g,
	output logic [`BDD_TYPE_W-1:0]   out_op
);

	import bdd_apply_pkg::*;

	apply_req_t  in_req;
	apply_req_t  req;
	logic        req_valid;
	logic        term_in_ready;
	logic        cache_in_ready;
	logic        term_valid;
	logic        cache_valid;
	logic        merge_ready;
	terminal_t   verdict;
	cache_req_t  lookup;
	apply_resp_t resp;

	assign in_req = '{id: in_id, negate: in_negate, f: in_f, g: in_g, op: bdd_op_t'(in_op)};

	bdd_pipe_reg #(.payload_t(apply_req_t)) req_reg (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_data  (in_req),
		.out_valid(req_valid),
		.out_ready(term_in_ready && cache_in_ready),
		.out_data (req)
	);

	// Each side takes the request only together with the other
	bdd_terminal_check term0 (
		.clk      (clk),
		.reset    (reset),
		.in_valid (req_valid && cache_in_ready),
		.in_ready (term_in_ready),
		.req      (req),
		.out_valid(term_valid),
		.out_ready(merge_ready),
		.verdict  (verdict)
	);

	bdd_cache_lookup cache0 (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (req_valid && term_in_ready),
		.in_ready     (cache_in_ready),
		.req          (req),
		.insert_valid (insert_valid),
		.insert_f     (insert_f),
		.insert_g     (insert_g),
		.insert_op    (insert_op),
		.insert_result(insert_result),
		.out_valid    (cache_valid),
		.out_ready    (merge_ready),
		.lookup       (lookup)
	);

	bdd_result_merge merge0 (
		.clk        (clk),
		.reset      (reset),
		.term_valid (term_valid),
		.verdict    (verdict),
		.cache_valid(cache_valid),
		.lookup     (lookup),
		.in_ready   (merge_ready),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.resp       (resp)
	);

	assign out_id = resp.id;
	assign out_hit = resp.hit;
	assign out_result = resp.result;
	assign out_f = resp.f;
	assign out_g = resp.g;
	assign out_op = resp.op;

endmodule

// ==== src/bdd_result_merge.sv ====
`timescale 1ns/100ps

`include "bdd_apply_macros.svh"

module bdd_result_merge (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       term_valid,
	input  bdd_apply_pkg::terminal_t   verdict,
	input  logic                       cache_valid,
	input  bdd_apply_pkg::cache_req_t  lookup,
	output logic                       in_ready,
	output logic                       out_valid,
	input  logic                       out_ready,
	output bdd_apply_pkg::apply_resp_t resp
);

	import bdd_apply_pkg::*;

	apply_resp_t             resp_d;
	logic [`BDD_INDEX_W-1:0] picked; // Terminal result wins over cache

	always_comb
	begin
		picked = verdict.hit ? verdict.result : lookup.result;
		resp_d.id = lookup.req.id;
		resp_d.hit = verdict.hit || lookup.hit;
		resp_d.result = picked;
		if (resp_d.hit)
		begin
			resp_d.result[0] = picked[0] ^ lookup.req.negate;
		end
		resp_d.f = lookup.req.f;
		resp_d.g = lookup.req.g;
		resp_d.op = lookup.req.op;
	end

	bdd_pipe_reg #(.payload_t(apply_resp_t)) resp_reg (
		.clk      (clk),
		.reset    (reset),
		.in_valid (term_valid && cache_valid),
		.in_ready (in_ready),
		.in_data  (resp_d),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data (resp)
	);

	// Both side paths load together, so they never drift apart
	a_lockstep: assert property (@(posedge clk) disable iff (reset)
		term_valid == cache_valid);

endmodule

// ==== src/bdd_cache_lookup.sv ====
`timescale 1ns/100ps

`include "bdd_apply_macros.svh"

module bdd_cache_lookup (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  bdd_apply_pkg::apply_req_t req,
	input  logic                      insert_valid,
	input  logic [`BDD_INDEX_W-1:0]   insert_f,
	input  logic [`BDD_INDEX_W-1:0]   insert_g,
	input  logic [`BDD_TYPE_W-1:0]    insert_op,
	input  logic [`BDD_INDEX_W-1:0]   insert_result,
	output logic                      out_valid,
	input  logic                      out_ready,
	output bdd_apply_pkg::cache_req_t lookup
);

	import bdd_apply_pkg::*;

	cache_entry_t                 cache_mem [`BDD_CACHE_DEPTH];
	logic [`BDD_CACHE_DEPTH-1:0]  entry_valid;
	apply_req_t                   ordered;
	bdd_op_t                      wr_op;
	logic [`BDD_CACHE_ADDR_W-1:0] rd_addr;
	logic [`BDD_CACHE_ADDR_W-1:0] wr_addr;
	apply_req_t                   req_q;
	cache_entry_t                 entry_q;
	logic                         entry_valid_q;
	logic                         tag_match;
	logic                         load;

	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	// Smaller index first for commutative ops
	always_comb
	begin
		ordered = req;
		if (is_commutative(req.op) && (req.f > req.g))
		begin
			ordered.f = req.g;
			ordered.g = req.f;
		end
	end

	assign wr_op = bdd_op_t'(insert_op);
	assign rd_addr = cache_hash(ordered.f, ordered.g, ordered.op);
	assign wr_addr = cache_hash(insert_f, insert_g, wr_op);

	always_ff @(posedge clk)
	begin
		if (insert_valid)
		begin
			cache_mem[wr_addr] <= '{f: insert_f, g: insert_g, op: wr_op, result: insert_result};
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			entry_valid <= '0; // Flushes the whole cache
		end
		else if (insert_valid)
		begin
			entry_valid[wr_addr] <= 1'b1;
		end
	end

	// Read port, old data when an insert hits the same edge
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			req_q <= ordered;
			entry_q <= cache_mem[rd_addr];
			entry_valid_q <= entry_valid[rd_addr];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
		end
	end

	// Full tag compare, the hash alone can alias
	assign tag_match = entry_valid_q && (entry_q.f == req_q.f) && (entry_q.g == req_q.g)
		&& (entry_q.op == req_q.op);

	assign lookup = '{req: req_q, hit: tag_match, result: entry_q.result};

	a_quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid);

endmodule

// ==== src/bdd_terminal_check.sv ====
`timescale 1ns/100ps

`include "bdd_apply_macros.svh"

module bdd_terminal_check (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  bdd_apply_pkg::apply_req_t req,
	output logic                     out_valid,
	input  logic                     out_ready,
	output bdd_apply_pkg::terminal_t verdict
);

	import bdd_apply_pkg::*;

	terminal_t verdict_d;
	logic      f_false;
	logic      f_true;
	logic      g_false;
	logic      g_true;
	logic      same;
	logic      opposite; // f is the complement of g

	assign f_false = (req.f == `BDD_NODE_FALSE);
	assign f_true = (req.f == `BDD_NODE_TRUE);
	assign g_false = (req.g == `BDD_NODE_FALSE);
	assign g_true = (req.g == `BDD_NODE_TRUE);
	assign same = (req.f == req.g);
	assign opposite = (req.f == (req.g ^ `BDD_NODE_TRUE));

	// Rules are symmetric in f and g, so raw operand order is fine
	always_comb
	begin
		verdict_d.hit = 1'b0;
		verdict_d.result = `BDD_NODE_FALSE;
		case (req.op)
			OP_AND:
			begin
				if (f_false || g_false || opposite)
				begin
					verdict_d.hit = 1'b1; // Result stays FALSE
				end
				else if (f_true || same)
				begin
					verdict_d.hit = 1'b1;
					verdict_d.result = req.g;
				end
				else if (g_true)
				begin
					verdict_d.hit = 1'b1;
					verdict_d.result = req.f;
				end
			end
			OP_OR:
			begin
				if (f_true || g_true || opposite)
				begin
					verdict_d.hit = 1'b1;
					verdict_d.result = `BDD_NODE_TRUE;
				end
				else if (f_false || same)
				begin
					verdict_d.hit = 1'b1;
					verdict_d.result = req.g;
				end
				else if (g_false)
				begin
					verdict_d.hit = 1'b1;
					verdict_d.result = req.f;
				end
			end
			OP_XOR:
			begin
				verdict_d.hit = f_false || g_false || same || opposite || f_true || g_true;
				if (f_false)
				begin
					verdict_d.result = req.g;
				end
				else if (g_false)
				begin
					verdict_d.result = req.f;
				end
				else if (opposite)
				begin
					verdict_d.result = `BDD_NODE_TRUE;
				end
				else if (f_true && !same)
				begin
					verdict_d.result = req.g ^ `BDD_NODE_TRUE; // Complement of g
				end
				else if (g_true && !same)
				begin
					verdict_d.result = req.f ^ `BDD_NODE_TRUE;
				end
			end
			OP_EXIST, OP_PERMUTE:
			begin
				verdict_d.hit = f_false || f_true; // Constant f passes through
				verdict_d.result = req.f;
			end
			default:
			begin
				verdict_d.hit = 1'b0;
			end
		endcase
	end

	bdd_pipe_reg #(.payload_t(terminal_t)) verdict_reg (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_data  (verdict_d),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data (verdict)
	);

endmodule

// ==== src/bdd_pipe_reg.sv ====
`timescale 1ns/100ps

module bdd_pipe_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic load;

	// Accept when the slot is free or drains this cycle
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			out_data <= in_data;
		end
	end

	// Stalled payload must not change under the consumer
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> $stable(out_data));

endmodule

// ==== src/bdd_apply_pkg.sv ====
`include "bdd_apply_macros.svh"

package bdd_apply_pkg;

	typedef enum logic [`BDD_TYPE_W-1:0] {
		OP_AND     = 3'd0,
		OP_OR      = 3'd1,
		OP_XOR     = 3'd2,
		OP_EXIST   = 3'd3,
		OP_PERMUTE = 3'd4
	} bdd_op_t;

	typedef struct packed {
		logic [`BDD_REQ_ID_W-1:0] id;
		logic                     negate; // Complement the final result
		logic [`BDD_INDEX_W-1:0]  f;
		logic [`BDD_INDEX_W-1:0]  g;
		bdd_op_t                  op;
	} apply_req_t;

	typedef struct packed {
		logic                    hit;
		logic [`BDD_INDEX_W-1:0] result;
	} terminal_t;

	typedef struct packed {
		apply_req_t              req; // Operands already in canonical order
		logic                    hit;
		logic [`BDD_INDEX_W-1:0] result;
	} cache_req_t;

	typedef struct packed {
		logic [`BDD_REQ_ID_W-1:0] id;
		logic                     hit;
		logic [`BDD_INDEX_W-1:0]  result;
		logic [`BDD_INDEX_W-1:0]  f;
		logic [`BDD_INDEX_W-1:0]  g;
		bdd_op_t                  op;
	} apply_resp_t;

	typedef struct packed {
		logic [`BDD_INDEX_W-1:0] f;
		logic [`BDD_INDEX_W-1:0] g;
		bdd_op_t                 op;
		logic [`BDD_INDEX_W-1:0] result;
	} cache_entry_t;

	// Folds low bytes of both operands, op lands in the top bits
	function automatic logic [`BDD_CACHE_ADDR_W-1:0] cache_hash(
		input logic [`BDD_INDEX_W-1:0] f,
		input logic [`BDD_INDEX_W-1:0] g,
		input bdd_op_t op
	);
		return f[7:0] ^ f[15:8] ^ g[7:0] ^ g[23:16] ^ {op, 5'b00000};
	endfunction

	function automatic logic is_commutative(input bdd_op_t op);
		return op inside {OP_AND, OP_OR, OP_XOR};
	endfunction

endpackage

// ==== src/bdd_apply_macros.svh ====
`ifndef BDD_APPLY_MACROS_SVH
`define BDD_APPLY_MACROS_SVH

// Node index, complement flag lives in bit 0
`define BDD_INDEX_W 30

// Operation code
`define BDD_TYPE_W 3

// Request tag returned with the response
`define BDD_REQ_ID_W 3

// Computed cache geometry
`define BDD_CACHE_ADDR_W 8
`define BDD_CACHE_DEPTH (1 << `BDD_CACHE_ADDR_W)

// Constant terminal nodes
`define BDD_NODE_FALSE {`BDD_INDEX_W{1'b0}}
`define BDD_NODE_TRUE {{(`BDD_INDEX_W-1){1'b0}}, 1'b1}

// Field widths of the packed payloads
//   apply_req_t   = id + negate + f + g + op
//   terminal_t    = hit + result
//   cache_req_t   = apply_req_t + hit + result
//   apply_resp_t  = id + hit + result + f + g + op
//   cache_entry_t = f + g + op + result
// XOR with BDD_NODE_TRUE flips the complement bit of an index

`endif
